/* design/ram_decoder_pkg.sv */
package ram_decoder_pkg;

   ////////////////////
   // bus widths

   // byte address seen by the manager
   localparam int ADDR_WIDTH = 32;
   // default word width in bits
   localparam int DATA_WIDTH = 32;
   // default transaction id width
   localparam int ID_WIDTH = 4;

   ////////////////////
   // region decode

   // set means kernel bank
   localparam int KERNEL_SEL_BIT = 31;
   // checked only when the kernel bit is clear
   localparam int ARG_SEL_BIT = 16;
   // low address bits handed to a bank as its offset
   localparam int OFFSET_WIDTH = 24;

   // one bit is enough for two banks
   localparam logic TARGET_KERNEL = 1'b0;
   localparam logic TARGET_ARG = 1'b1;

   ////////////////////
   // response codes

   // banks never fail a transfer
   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* design/axi_lite_if.sv */
interface axi_lite_if #(
   parameter int DATA_WIDTH = ram_decoder_pkg::DATA_WIDTH,
   parameter int ID_WIDTH = ram_decoder_pkg::ID_WIDTH
);
   import ram_decoder_pkg::*;

   // write address
   logic                    awvalid;
   logic                    awready;
   logic [ADDR_WIDTH-1:0]   awaddr;
   logic [ID_WIDTH-1:0]     awid;
   // write data, one beat only
   logic                    wvalid;
   logic                    wready;
   logic [DATA_WIDTH-1:0]   wdata;
   logic [DATA_WIDTH/8-1:0] wstrb;
   // write response
   logic                    bvalid;
   logic                    bready;
   logic [ID_WIDTH-1:0]     bid;
   logic [1:0]              bresp;
   // read address
   logic                    arvalid;
   logic                    arready;
   logic [ADDR_WIDTH-1:0]   araddr;
   logic [ID_WIDTH-1:0]     arid;
   // read data
   logic                    rvalid;
   logic                    rready;
   logic [DATA_WIDTH-1:0]   rdata;
   logic [ID_WIDTH-1:0]     rid;
   logic [1:0]              rresp;
   logic                    rlast;

   // requester side
   modport manager (
      output awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
      output arvalid, araddr, arid, rready,
      input  awready, wready, bvalid, bid, bresp,
      input  arready, rvalid, rdata, rid, rresp, rlast
   );

   // responder side
   modport subordinate (
      input  awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
      input  arvalid, araddr, arid, rready,
      output awready, wready, bvalid, bid, bresp,
      output arready, rvalid, rdata, rid, rresp, rlast
   );

endinterface

/* design/region_router.sv */
module region_router #(
   parameter int DATA_WIDTH = ram_decoder_pkg::DATA_WIDTH,
   parameter int ID_WIDTH = ram_decoder_pkg::ID_WIDTH
) (
   input logic             clk,
   input logic             arst_n,
   axi_lite_if.subordinate host,
   axi_lite_if.manager     kernel_port,
   axi_lite_if.manager     arg_port
);
   import ram_decoder_pkg::*;

   // bit 31 wins over bit 16 and anything else falls to the kernel bank
   function automatic logic decode_target(input logic [ADDR_WIDTH-1:0] addr);
      if (addr[KERNEL_SEL_BIT]) begin
         return TARGET_KERNEL;
      end
      if (addr[ARG_SEL_BIT]) begin
         return TARGET_ARG;
      end
      return TARGET_KERNEL;
   endfunction

   ////////////////////
   // write path

   logic                wr_busy;
   logic                wr_target;
   logic                wr_sel;
   logic                wr_accept;
   logic                wr_done;
   logic [ID_WIDTH-1:0] bid_mux;

   // live decode while idle
   assign wr_sel = decode_target(host.awaddr);
   // aw and w go together
   assign wr_accept = host.awvalid && host.wvalid && host.awready && host.wready;
   assign wr_done = host.bvalid && host.bready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_busy <= 1'b0;
         wr_target <= TARGET_KERNEL;
      end else if (wr_accept) begin
         wr_busy <= 1'b1;
         wr_target <= wr_sel;
      end else if (wr_done) begin
         wr_busy <= 1'b0;
      end
   end

   // valids reach the selected bank only
   assign kernel_port.awvalid = host.awvalid && !wr_busy && (wr_sel == TARGET_KERNEL);
   assign arg_port.awvalid = host.awvalid && !wr_busy && (wr_sel == TARGET_ARG);
   assign kernel_port.wvalid = host.wvalid && !wr_busy && (wr_sel == TARGET_KERNEL);
   assign arg_port.wvalid = host.wvalid && !wr_busy && (wr_sel == TARGET_ARG);

   // no new write while a b response waits
   assign host.awready = !wr_busy &&
                         ((wr_sel == TARGET_ARG) ? arg_port.awready : kernel_port.awready);
   assign host.wready = !wr_busy &&
                        ((wr_sel == TARGET_ARG) ? arg_port.wready : kernel_port.wready);

   // payload broadcast to both banks
   assign kernel_port.awaddr = host.awaddr;
   assign kernel_port.awid = host.awid;
   assign kernel_port.wdata = host.wdata;
   assign kernel_port.wstrb = host.wstrb;
   assign arg_port.awaddr = host.awaddr;
   assign arg_port.awid = host.awid;
   assign arg_port.wdata = host.wdata;
   assign arg_port.wstrb = host.wstrb;

   // b channel follows the latched target
   assign bid_mux = (wr_target == TARGET_ARG) ? arg_port.bid : kernel_port.bid;
   assign host.bid = bid_mux;
   assign host.bresp = (wr_target == TARGET_ARG) ? arg_port.bresp : kernel_port.bresp;
   assign host.bvalid = wr_busy &&
                        ((wr_target == TARGET_ARG) ? arg_port.bvalid : kernel_port.bvalid);
   assign kernel_port.bready = host.bready && wr_busy && (wr_target == TARGET_KERNEL);
   assign arg_port.bready = host.bready && wr_busy && (wr_target == TARGET_ARG);

   ////////////////////
   // read path

   logic                  rd_busy;
   logic                  rd_target;
   logic                  rd_sel;
   logic                  rd_accept;
   logic                  rd_done;
   logic [ID_WIDTH-1:0]   rid_mux;
   logic [DATA_WIDTH-1:0] rdata_mux;

   assign rd_sel = decode_target(host.araddr);
   assign rd_accept = host.arvalid && host.arready;
   assign rd_done = host.rvalid && host.rready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_busy <= 1'b0;
         rd_target <= TARGET_KERNEL;
      end else if (rd_accept) begin
         rd_busy <= 1'b1;
         rd_target <= rd_sel;
      end else if (rd_done) begin
         rd_busy <= 1'b0;
      end
   end

   assign kernel_port.arvalid = host.arvalid && !rd_busy && (rd_sel == TARGET_KERNEL);
   assign arg_port.arvalid = host.arvalid && !rd_busy && (rd_sel == TARGET_ARG);
   assign host.arready = !rd_busy &&
                         ((rd_sel == TARGET_ARG) ? arg_port.arready : kernel_port.arready);

   assign kernel_port.araddr = host.araddr;
   assign kernel_port.arid = host.arid;
   assign arg_port.araddr = host.araddr;
   assign arg_port.arid = host.arid;

   // r channel from the bank that took the ar
   assign rdata_mux = (rd_target == TARGET_ARG) ? arg_port.rdata : kernel_port.rdata;
   assign rid_mux = (rd_target == TARGET_ARG) ? arg_port.rid : kernel_port.rid;
   assign host.rdata = rdata_mux;
   assign host.rid = rid_mux;
   assign host.rresp = (rd_target == TARGET_ARG) ? arg_port.rresp : kernel_port.rresp;
   assign host.rlast = (rd_target == TARGET_ARG) ? arg_port.rlast : kernel_port.rlast;
   assign host.rvalid = rd_busy &&
                        ((rd_target == TARGET_ARG) ? arg_port.rvalid : kernel_port.rvalid);
   assign kernel_port.rready = host.rready && rd_busy && (rd_target == TARGET_KERNEL);
   assign arg_port.rready = host.rready && rd_busy && (rd_target == TARGET_ARG);

   ////////////////////
   // checks

   // response must come back from the bank that took the request
   wr_target_held: assert property (
      @(posedge clk) disable iff (!arst_n) wr_busy |=> $stable(wr_target)
   );
   rd_target_held: assert property (
      @(posedge clk) disable iff (!arst_n) rd_busy |=> $stable(rd_target)
   );

endmodule

/* design/axi_ram_bank.sv */
module axi_ram_bank #(
   parameter int DATA_WIDTH = ram_decoder_pkg::DATA_WIDTH,
   parameter int ID_WIDTH = ram_decoder_pkg::ID_WIDTH,
   parameter int RAM_DEPTH = 256
) (
   input logic             clk,
   input logic             arst_n,
   axi_lite_if.subordinate bus
);
   import ram_decoder_pkg::*;

   localparam int BYTES = DATA_WIDTH / 8;
   localparam int BYTE_BITS = $clog2(BYTES);
   localparam int IDX_WIDTH = $clog2(RAM_DEPTH);
   localparam logic [OFFSET_WIDTH-1:0] DEPTH_OFF = OFFSET_WIDTH'(RAM_DEPTH);

   // word storage
   logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

   // byte offset to word index
   // offsets past the end wrap onto lower words
   function automatic logic [IDX_WIDTH-1:0] word_index(input logic [ADDR_WIDTH-1:0] addr);
      logic [OFFSET_WIDTH-1:0] word_off;
      logic [OFFSET_WIDTH-1:0] wrapped;
      word_off = addr[OFFSET_WIDTH-1:0] >> BYTE_BITS;
      wrapped = word_off % DEPTH_OFF;
      return wrapped[IDX_WIDTH-1:0];
   endfunction

   ////////////////////
   // write side

   logic                 bvalid_q;
   logic [ID_WIDTH-1:0]  bid_q;
   logic                 wr_fire;
   logic [IDX_WIDTH-1:0] wr_idx;

   // aw and w taken in the same cycle
   assign wr_fire = bus.awvalid && bus.wvalid && !bvalid_q;
   assign wr_idx = word_index(bus.awaddr);

   // strobed byte lanes only
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         for (int b = 0; b < BYTES; b++) begin
            if (bus.wstrb[b]) begin
               mem[wr_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bvalid_q <= 1'b0;
      end else if (wr_fire) begin
         bvalid_q <= 1'b1;
      end else if (bus.bready) begin
         bvalid_q <= 1'b0;
      end
   end

   // echo the id back with the response
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         bid_q <= bus.awid;
      end
   end

   // stall new writes while b is pending
   assign bus.awready = !bvalid_q;
   assign bus.wready = !bvalid_q;
   assign bus.bvalid = bvalid_q;
   assign bus.bid = bid_q;
   assign bus.bresp = RESP_OKAY;

   ////////////////////
   // read side

   logic                  rvalid_q;
   logic [ID_WIDTH-1:0]   rid_q;
   logic [DATA_WIDTH-1:0] rdata_q;
   logic                  rd_fire;
   logic [IDX_WIDTH-1:0]  rd_idx;

   assign rd_fire = bus.arvalid && !rvalid_q;
   assign rd_idx = word_index(bus.araddr);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rvalid_q <= 1'b0;
      end else if (rd_fire) begin
         rvalid_q <= 1'b1;
      end else if (bus.rready) begin
         rvalid_q <= 1'b0;
      end
   end

   // word and id held until rready
   always_ff @(posedge clk) begin
      if (rd_fire) begin
         rdata_q <= mem[rd_idx];
         rid_q <= bus.arid;
      end
   end

   assign bus.arready = !rvalid_q;
   assign bus.rvalid = rvalid_q;
   assign bus.rdata = rdata_q;
   assign bus.rid = rid_q;
   assign bus.rresp = RESP_OKAY;
   // single beat so always last
   assign bus.rlast = 1'b1;

   ////////////////////
   // checks

   b_held: assert property (
      @(posedge clk) disable iff (!arst_n)
      bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bid)
   );
   r_held: assert property (
      @(posedge clk) disable iff (!arst_n)
      bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata) && $stable(bus.rid)
   );

endmodule

/* design/ram_decoder.sv */
module ram_decoder #(
   parameter int DATA_WIDTH = ram_decoder_pkg::DATA_WIDTH,
   parameter int ID_WIDTH = ram_decoder_pkg::ID_WIDTH,
   parameter int KERNEL_DEPTH = 256,
   parameter int ARG_DEPTH = 256
) (
   input  logic                                  clk,
   input  logic                                  arst_n,
   // write address
   input  logic                                  s_axi_awvalid,
   output logic                                  s_axi_awready,
   input  logic [ram_decoder_pkg::ADDR_WIDTH-1:0] s_axi_awaddr,
   input  logic [ID_WIDTH-1:0]                   s_axi_awid,
   // write data
   input  logic                                  s_axi_wvalid,
   output logic                                  s_axi_wready,
   input  logic [DATA_WIDTH-1:0]                 s_axi_wdata,
   input  logic [DATA_WIDTH/8-1:0]               s_axi_wstrb,
   // write response
   output logic                                  s_axi_bvalid,
   input  logic                                  s_axi_bready,
   output logic [ID_WIDTH-1:0]                   s_axi_bid,
   output logic [1:0]                            s_axi_bresp,
   // read address
   input  logic                                  s_axi_arvalid,
   output logic                                  s_axi_arready,
   input  logic [ram_decoder_pkg::ADDR_WIDTH-1:0] s_axi_araddr,
   input  logic [ID_WIDTH-1:0]                   s_axi_arid,
   // read data
   output logic                                  s_axi_rvalid,
   input  logic                                  s_axi_rready,
   output logic [DATA_WIDTH-1:0]                 s_axi_rdata,
   output logic [ID_WIDTH-1:0]                   s_axi_rid,
   output logic [1:0]                            s_axi_rresp,
   output logic                                  s_axi_rlast
);

   // host side plus one bus per bank
   axi_lite_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) host_bus ();
   axi_lite_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) kernel_bus ();
   axi_lite_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) arg_bus ();

   ////////////////////
   // ports onto host bus

   assign host_bus.awvalid = s_axi_awvalid;
   assign host_bus.awaddr = s_axi_awaddr;
   assign host_bus.awid = s_axi_awid;
   assign host_bus.wvalid = s_axi_wvalid;
   assign host_bus.wdata = s_axi_wdata;
   assign host_bus.wstrb = s_axi_wstrb;
   assign host_bus.bready = s_axi_bready;
   assign host_bus.arvalid = s_axi_arvalid;
   assign host_bus.araddr = s_axi_araddr;
   assign host_bus.arid = s_axi_arid;
   assign host_bus.rready = s_axi_rready;

   assign s_axi_awready = host_bus.awready;
   assign s_axi_wready = host_bus.wready;
   assign s_axi_bvalid = host_bus.bvalid;
   assign s_axi_bid = host_bus.bid;
   assign s_axi_bresp = host_bus.bresp;
   assign s_axi_arready = host_bus.arready;
   assign s_axi_rvalid = host_bus.rvalid;
   assign s_axi_rdata = host_bus.rdata;
   assign s_axi_rid = host_bus.rid;
   assign s_axi_rresp = host_bus.rresp;
   assign s_axi_rlast = host_bus.rlast;

   ////////////////////
   // router and banks

   region_router #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) router (
      .clk         (clk),
      .arst_n      (arst_n),
      .host        (host_bus.subordinate),
      .kernel_port (kernel_bus.manager),
      .arg_port    (arg_bus.manager)
   );

   // bit 31 region and the default region
   axi_ram_bank #(
      .DATA_WIDTH (DATA_WIDTH),
      .ID_WIDTH   (ID_WIDTH),
      .RAM_DEPTH  (KERNEL_DEPTH)
   ) kernel_ram (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (kernel_bus.subordinate)
   );

   // bit 16 region
   axi_ram_bank #(
      .DATA_WIDTH (DATA_WIDTH),
      .ID_WIDTH   (ID_WIDTH),
      .RAM_DEPTH  (ARG_DEPTH)
   ) arg_ram (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (arg_bus.subordinate)
   );

endmodule

/* verification/tb_ram_decoder.sv */
module tb_ram_decoder;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 5000;

   logic        clk;
   logic        arst_n;
   logic        s_axi_awvalid;
   logic        s_axi_awready;
   logic [31:0] s_axi_awaddr;
   logic [3:0]  s_axi_awid;
   logic        s_axi_wvalid;
   logic        s_axi_wready;
   logic [31:0] s_axi_wdata;
   logic [3:0]  s_axi_wstrb;
   logic        s_axi_bvalid;
   logic        s_axi_bready;
   logic [3:0]  s_axi_bid;
   logic [1:0]  s_axi_bresp;
   logic        s_axi_arvalid;
   logic        s_axi_arready;
   logic [31:0] s_axi_araddr;
   logic [3:0]  s_axi_arid;
   logic        s_axi_rvalid;
   logic        s_axi_rready;
   logic [31:0] s_axi_rdata;
   logic [3:0]  s_axi_rid;
   logic [1:0]  s_axi_rresp;
   logic        s_axi_rlast;

   int          errors = 0;
   int          checks = 0;
   int          cycle_count = 0;
   logic [31:0] lfsr_state = 32'he348_11eb;

   // model words per bank, plus which bits were ever written
   logic [31:0] ref_data  [2][256];
   logic [31:0] ref_known [2][256];

   ram_decoder #(
      .DATA_WIDTH   (32),
      .ID_WIDTH     (4),
      .KERNEL_DEPTH (256),
      .ARG_DEPTH    (256)
   ) uut (.*);

   ////////////////////
   // clock and watchdog

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin
      wait (cycle_count == TIMEOUT_CYCLES);
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
   end

   ////////////////////
   // helpers

   // taps 32 22 2 1
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   // one step per bit
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   // 0 kernel, 1 arg
   function automatic int region_of(input logic [31:0] addr);
      if (addr[31]) begin
         return 0;
      end
      return addr[16] ? 1 : 0;
   endfunction

   // 24 bit offset, 4 byte words, 256 deep
   function automatic int index_of(input logic [31:0] addr);
      return int'(addr[23:2]) % 256;
   endfunction

   function automatic logic [31:0] strb_mask(input logic [3:0] strb);
      logic [31:0] m;
      for (int b = 0; b < 4; b++) begin
         m[b*8 +: 8] = {8{strb[b]}};
      end
      return m;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   ////////////////////
   // bus tasks, called on a falling edge

   task automatic do_write(input logic [31:0] addr, input logic [3:0] id,
                           input logic [31:0] data, input logic [3:0] strb, input int hold);
      int          lat;
      int          bank;
      int          idx;
      logic [31:0] m;
      bank = region_of(addr);
      idx = index_of(addr);
      m = strb_mask(strb);
      s_axi_awvalid = 1'b1;
      s_axi_awaddr = addr;
      s_axi_awid = id;
      s_axi_wvalid = 1'b1;
      s_axi_wdata = data;
      s_axi_wstrb = strb;
      s_axi_bready = 1'b0;
      while (!(s_axi_awready && s_axi_wready)) begin
         @(negedge clk);
      end
      // taken at the next rising edge
      ref_data[bank][idx] = (ref_data[bank][idx] & ~m) | (data & m);
      ref_known[bank][idx] = ref_known[bank][idx] | m;
      @(negedge clk);
      s_axi_awvalid = 1'b0;
      s_axi_wvalid = 1'b0;
      lat = 1;
      while (!s_axi_bvalid) begin
         @(negedge clk);
         lat++;
      end
      check("b latency", lat, 1);
      check("bid", 32'(s_axi_bid), 32'(id));
      check("bresp", 32'(s_axi_bresp), 0);
      // response must hold while bready is low
      repeat (hold) begin
         check("awready busy", 32'(s_axi_awready), 0);
         check("wready busy", 32'(s_axi_wready), 0);
         @(negedge clk);
         check("bvalid held", 32'(s_axi_bvalid), 1);
         check("bid held", 32'(s_axi_bid), 32'(id));
      end
      s_axi_bready = 1'b1;
      @(negedge clk);
      s_axi_bready = 1'b0;
      check("bvalid after b", 32'(s_axi_bvalid), 0);
      check("awready after b", 32'(s_axi_awready), 1);
   endtask

   task automatic do_read(input logic [31:0] addr, input logic [3:0] id, input int hold,
                          output logic [31:0] data);
      int          lat;
      int          bank;
      int          idx;
      logic [31:0] first;
      bank = region_of(addr);
      idx = index_of(addr);
      s_axi_arvalid = 1'b1;
      s_axi_araddr = addr;
      s_axi_arid = id;
      s_axi_rready = 1'b0;
      while (!s_axi_arready) begin
         @(negedge clk);
      end
      @(negedge clk);
      s_axi_arvalid = 1'b0;
      lat = 1;
      while (!s_axi_rvalid) begin
         @(negedge clk);
         lat++;
      end
      first = s_axi_rdata;
      check("r latency", lat, 1);
      check("rid", 32'(s_axi_rid), 32'(id));
      check("rresp", 32'(s_axi_rresp), 0);
      check("rlast", 32'(s_axi_rlast), 1);
      // only bytes the model knows
      check("rdata model", first & ref_known[bank][idx],
            ref_data[bank][idx] & ref_known[bank][idx]);
      repeat (hold) begin
         check("arready busy", 32'(s_axi_arready), 0);
         @(negedge clk);
         check("rvalid held", 32'(s_axi_rvalid), 1);
         check("rid held", 32'(s_axi_rid), 32'(id));
         check("rdata held", s_axi_rdata, first);
      end
      s_axi_rready = 1'b1;
      @(negedge clk);
      s_axi_rready = 1'b0;
      check("rvalid after r", 32'(s_axi_rvalid), 0);
      check("arready after r", 32'(s_axi_arready), 1);
      data = first;
   endtask

   ////////////////////
   // directed tests

   task automatic test_reset_state();
      check("bvalid reset", 32'(s_axi_bvalid), 0);
      check("rvalid reset", 32'(s_axi_rvalid), 0);
      check("awready reset", 32'(s_axi_awready), 1);
      check("wready reset", 32'(s_axi_wready), 1);
      check("arready reset", 32'(s_axi_arready), 1);
   endtask

   task automatic test_kernel_bank();
      logic [31:0] d;
      do_write(32'h8000_0040, 4'h3, 32'hcafe_f00d, 4'hf, 0);
      do_read(32'h8000_0040, 4'h5, 0, d);
      check("kernel rdata", d, 32'hcafe_f00d);
      // default region lands on the same kernel word
      do_read(32'h0000_0040, 4'h9, 0, d);
      check("default rdata", d, 32'hcafe_f00d);
   endtask

   task automatic test_bank_separation();
      logic [31:0] d;
      do_write(32'h8000_0080, 4'h1, 32'h1357_9bdf, 4'hf, 0);
      do_write(32'h0001_0080, 4'h2, 32'h2468_ace0, 4'hf, 0);
      do_read(32'h8000_0080, 4'h4, 0, d);
      check("kernel word", d, 32'h1357_9bdf);
      do_read(32'h0001_0080, 4'h6, 0, d);
      check("arg word", d, 32'h2468_ace0);
   endtask

   task automatic test_byte_strobes();
      logic [31:0] d;
      do_write(32'h8000_00c0, 4'h7, 32'h1122_3344, 4'hf, 0);
      do_write(32'h8000_00c0, 4'h8, 32'haabb_ccdd, 4'b0101, 0);
      do_read(32'h8000_00c0, 4'ha, 0, d);
      check("strobed word", d, 32'h11bb_33dd);
   endtask

   task automatic test_back_pressure();
      logic [31:0] d;
      do_write(32'h0001_0100, 4'hc, 32'h0bad_beef, 4'hf, 6);
      do_read(32'h0001_0100, 4'hd, 6, d);
      check("held rdata", d, 32'h0bad_beef);
   endtask

   task automatic test_random_traffic();
      logic [31:0] addr;
      logic [31:0] d;
      int          region;
      for (int n = 0; n < 200; n++) begin
         // 16 words per bank, upper offset bits alias
         addr = next_bits(22) << 10;
         addr[5:0] = 6'(next_bits(6));
         region = int'(next_bits(2)) % 3;
         addr[31] = (region == 0);
         addr[16] = (region == 1);
         if (next_bits(1) != 0) begin
            do_write(addr, 4'(next_bits(4)), next_bits(32), 4'(next_bits(4)),
                     int'(next_bits(2)));
         end else begin
            do_read(addr, 4'(next_bits(4)), int'(next_bits(2)), d);
         end
      end
   endtask

   ////////////////////
   // main sequence

   initial begin
      for (int b = 0; b < 2; b++) begin
         for (int i = 0; i < 256; i++) begin
            ref_data[b][i] = '0;
            ref_known[b][i] = '0;
         end
      end
      arst_n = 1'b0;
      s_axi_awvalid = 1'b0;
      s_axi_awaddr = '0;
      s_axi_awid = '0;
      s_axi_wvalid = 1'b0;
      s_axi_wdata = '0;
      s_axi_wstrb = '0;
      s_axi_bready = 1'b0;
      s_axi_arvalid = 1'b0;
      s_axi_araddr = '0;
      s_axi_arid = '0;
      s_axi_rready = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      test_reset_state();
      test_kernel_bank();
      test_bank_separation();
      test_byte_strobes();
      test_back_pressure();
      test_random_traffic();
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* compile.f */
design/ram_decoder_pkg.sv
design/axi_lite_if.sv
design/region_router.sv
design/axi_ram_bank.sv
design/ram_decoder.sv
verification/tb_ram_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_ram_decoder \
   -f compile.f

out="$(./obj_dir/Vtb_ram_decoder)"
echo "$out"

if grep -q "all tests passed" <<< "$out"; then
   exit 0
else
   exit 1
fi
